//--- common/secv_mem_pkg.sv
// Word addressed bus, region bases must be aligned to their own size, single package for the design
package secv_mem_pkg;

    // Bus geometry
    localparam int BUS_ADDR_W = 12;             // Word address, 4096 words of space
    localparam int DATA_W     = 32;             // One word per beat
    localparam int SEL_W      = DATA_W / 8;     // One select bit per byte lane

    // Memory depths as word-address widths
    localparam int IMEM_AW = 10;                // 1024 words of instruction RAM
    localparam int DMEM_AW = 9;                 // 512 words of data RAM

    // Region bases, word addresses
    // Each base has zeros in the low bits covered by its region
    localparam logic [BUS_ADDR_W-1:0] IMEM_BASE = 12'h000;  // 0x000 .. 0x3ff
    localparam logic [BUS_ADDR_W-1:0] DMEM_BASE = 12'h800;  // 0x800 .. 0x9ff

    // Anything else is unmapped
    // 0x400 .. 0x7ff and 0xa00 .. 0xfff answer with err

    // Memory clearing
    // Set means every RAM word is zeroed while RESET_MEM is high
    // Cleared means contents survive reset and start undefined
    localparam logic MEM_CLEAR_ON_RESET = 1'b1;

    // Response timing, for reference
    // RAM ack and read data one cycle after stb
    // Decoder err one cycle after an unmapped stb
    // Arbiter grants an idle bus in the same cycle

    // Byte lanes
    // Lane 0 is dat[7:0], little-endian inside the word
    // Unselected lanes read as zero

    // Bus masters
    // Instruction fetch reads only
    // Data port reads and writes
    // Data port wins when both start on an idle bus

endpackage

//--- common/wb_if.sv
// Wishbone classic only, no burst or tag signals, one response per strobe
`timescale 1ns/1ns

interface wb_if #(
    parameter int AW = secv_mem_pkg::BUS_ADDR_W    // Word address width of this link
);
    import secv_mem_pkg::*;

    // Request side
    logic              cyc;     // Bus cycle in progress, also holds the grant
    logic              stb;     // Valid transfer
    logic              we;      // Write when high
    logic [AW-1:0]     adr;     // Word address
    logic [SEL_W-1:0]  sel;     // Byte lanes
    logic [DATA_W-1:0] dat_w;   // Write data

    // Response side
    logic [DATA_W-1:0] dat_r;   // Read data, valid with ack only
    logic              ack;     // Normal termination, one cycle
    logic              err;     // Error termination, one cycle

    // Initiator view
    modport master (
        output cyc, stb, we, adr, sel, dat_w,
        input  dat_r, ack, err
    );

    // Target view
    modport slave (
        input  cyc, stb, we, adr, sel, dat_w,
        output dat_r, ack, err
    );

    // Ack and err never together
    // Master holds request until one of them

endinterface

//--- ram_wb/ram_wb.sv
// Single-cycle Wishbone RAM, depth 2**ADDR_WIDTH words, adr must be at least ADDR_WIDTH bits
`timescale 1ns/1ns

module ram_wb #(
    parameter int ADDR_WIDTH = 8        // Word address bits
) (
    input  logic clk_i,
    input  logic RESET_MEM,             // Sync, active high
    wb_if.slave  bus_s
);
    import secv_mem_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [DATA_W-1:0]     mem [DEPTH];     // Storage, little-endian lanes
    logic [ADDR_WIDTH-1:0] word_adr;        // Index into mem
    logic                  access;          // Strobe seen this cycle
    logic                  ack_q;           // Registered ack
    logic [DATA_W-1:0]     dat_q;           // Registered read data

    // Elaboration checks on the geometry
    if (ADDR_WIDTH < 1) begin : g_chk_aw_min
        $error("ram_wb: ADDR_WIDTH must be at least 1");
    end

    if (ADDR_WIDTH > BUS_ADDR_W) begin : g_chk_aw_max
        $error("ram_wb: ADDR_WIDTH wider than the bus word address");
    end

    if ((DATA_W % 8 != 0) || ($countones(DATA_W) != 1)) begin : g_chk_dw
        $error("ram_wb: DATA_W must be a power of two and whole bytes");
    end

    if (SEL_W != DATA_W / 8) begin : g_chk_sel
        $error("ram_wb: SEL_W must equal the byte count of a word");
    end

    assign word_adr = bus_s.adr[ADDR_WIDTH-1:0];   // Low bits only

    // No second ack for the same strobe
    // Master drops stb one cycle after ack, so skip that cycle
    assign access = bus_s.cyc && bus_s.stb && !ack_q;

    always_ff @(posedge clk_i) begin
        // Default every cycle, read data only lives in the ack cycle
        dat_q <= '0;
        ack_q <= 1'b0;

        if (RESET_MEM) begin
            if (MEM_CLEAR_ON_RESET) begin
                for (int i = 0; i < DEPTH; i++) begin
                    mem[i] <= '0;               // Whole array zeroed
                end
            end
        end else if (access) begin
            ack_q <= 1'b1;                      // Reads and writes alike
            for (int b = 0; b < SEL_W; b++) begin
                if (bus_s.sel[b]) begin
                    if (bus_s.we) begin
                        mem[word_adr][b*8 +: 8] <= bus_s.dat_w[b*8 +: 8];  // Lane write
                    end else begin
                        dat_q[b*8 +: 8] <= mem[word_adr][b*8 +: 8];        // Lane read
                    end
                end
                // Unselected lanes keep the zero default
            end
        end
    end

    // Responses
    assign bus_s.dat_r = dat_q;
    assign bus_s.ack   = ack_q;
    assign bus_s.err   = 1'b0;                  // Every address inside the RAM is valid

    // Writes also return zero data
    // Depth is the only difference between instances

endmodule

//--- hdl/wb_arbiter.sv
// Two masters, fixed priority for data on an idle bus, grant held until owner drops cyc
`timescale 1ns/1ns

module wb_arbiter (
    input  logic clk_i,
    input  logic RESET_MEM,         // Sync, active high
    wb_if.slave  fetch_s,           // Instruction fetch master
    wb_if.slave  data_s,            // Data master
    wb_if.master bus_m              // Shared bus toward the decoder
);
    import secv_mem_pkg::*;

    logic active_q;                 // Bus owned by someone
    logic owner_q;                  // High when data master owns the bus
    logic owner_cyc;                // Registered owner still in its cycle
    logic grant_data;               // Current grant, high selects data

    // Owner of the last cycle and its cyc
    assign owner_cyc = owner_q ? data_s.cyc : fetch_s.cyc;

    // Locked grant while the owner holds cyc
    // Otherwise idle, data first, same-cycle grant
    assign grant_data = (active_q && owner_cyc) ? owner_q : data_s.cyc;

    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            active_q <= 1'b0;
            owner_q  <= 1'b0;
        end else begin
            active_q <= bus_m.cyc;          // Released when owner's cyc falls
            owner_q  <= grant_data;
        end
    end

    // Request path from the granted master
    assign bus_m.cyc   = grant_data ? data_s.cyc   : fetch_s.cyc;
    assign bus_m.stb   = grant_data ? data_s.stb   : fetch_s.stb;
    assign bus_m.we    = grant_data ? data_s.we    : fetch_s.we;
    assign bus_m.adr   = grant_data ? data_s.adr   : fetch_s.adr;
    assign bus_m.sel   = grant_data ? data_s.sel   : fetch_s.sel;
    assign bus_m.dat_w = grant_data ? data_s.dat_w : fetch_s.dat_w;

    // Responses only to the owner
    // The waiting master sees nothing and keeps its request
    assign data_s.ack   = grant_data  && bus_m.ack;
    assign data_s.err   = grant_data  && bus_m.err;
    assign data_s.dat_r = grant_data  ? bus_m.dat_r : '0;

    assign fetch_s.ack   = !grant_data && bus_m.ack;
    assign fetch_s.err   = !grant_data && bus_m.err;
    assign fetch_s.dat_r = !grant_data ? bus_m.dat_r : {DATA_W{1'b0}};

    // Owner never drops cyc before its response
    // so no response is left in flight for the old owner

endmodule

//--- hdl/wb_decoder.sv
// Two mapped regions, routing is combinational, unmapped strobes get a registered err
`timescale 1ns/1ns

module wb_decoder (
    input  logic clk_i,
    input  logic RESET_MEM,         // Sync, active high
    wb_if.slave  bus_s,             // From the arbiter
    wb_if.master imem_m,            // To instruction RAM
    wb_if.master dmem_m             // To data RAM
);
    import secv_mem_pkg::*;

    logic hit_imem;                 // Address inside instruction region
    logic hit_dmem;                 // Address inside data region
    logic miss;                     // No region claims the address
    logic err_q;                    // Registered error response

    // Compare the bits above each region's offset
    assign hit_imem = bus_s.adr[BUS_ADDR_W-1:IMEM_AW] == IMEM_BASE[BUS_ADDR_W-1:IMEM_AW];
    assign hit_dmem = bus_s.adr[BUS_ADDR_W-1:DMEM_AW] == DMEM_BASE[BUS_ADDR_W-1:DMEM_AW];
    assign miss     = !hit_imem && !hit_dmem;

    // Instruction RAM request
    // Bases are size-aligned, so the offset is just the low bits
    assign imem_m.cyc   = bus_s.cyc;
    assign imem_m.stb   = bus_s.stb && hit_imem;   // Strobe only on a match
    assign imem_m.we    = bus_s.we;
    assign imem_m.adr   = bus_s.adr[IMEM_AW-1:0];
    assign imem_m.sel   = bus_s.sel;
    assign imem_m.dat_w = bus_s.dat_w;

    // Data RAM request
    assign dmem_m.cyc   = bus_s.cyc;
    assign dmem_m.stb   = bus_s.stb && hit_dmem;
    assign dmem_m.we    = bus_s.we;
    assign dmem_m.adr   = bus_s.adr[DMEM_AW-1:0];
    assign dmem_m.sel   = bus_s.sel;
    assign dmem_m.dat_w = bus_s.dat_w;

    // Error for unmapped access, one cycle after stb
    // Skip the cycle right after err so one strobe gives one pulse
    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            err_q <= 1'b0;
        end else begin
            err_q <= bus_s.cyc && bus_s.stb && miss && !err_q;
        end
    end

    // Response mux
    // Address is held until the response, so it still names the target
    assign bus_s.dat_r = hit_imem ? imem_m.dat_r :
                         hit_dmem ? dmem_m.dat_r : '0;

    assign bus_s.ack = (hit_imem && imem_m.ack) ||
                       (hit_dmem && dmem_m.ack);

    // Err from a slave passes through as well
    assign bus_s.err = err_q ||
                       (hit_imem && imem_m.err) ||
                       (hit_dmem && dmem_m.err);

    // err_q only on a miss, acks only on a hit
    // so ack and err cannot meet

    // Regions cannot overlap
    // IMEM covers the low quarter, DMEM half a quarter at 0x800

    // Write data and select go to both RAMs
    // Only the strobed one acts on them

    // Unmapped writes touch no RAM
    // Contents stay as they were

    // Cyc is shared, strobe carries the selection

endmodule

//--- hdl/secv_mem_top.sv
// Memory subsystem top, Wishbone classic on both ports, fetch port is read-only
`timescale 1ns/1ns

module secv_mem_top (
    input  logic                              clk_i,
    input  logic                              RESET_MEM,   // Sync, active high

    // Instruction fetch port, read-only
    input  logic                              if_cyc_i,
    input  logic                              if_stb_i,
    input  logic [secv_mem_pkg::BUS_ADDR_W-1:0] if_adr_i,
    input  logic [secv_mem_pkg::SEL_W-1:0]    if_sel_i,
    output logic [secv_mem_pkg::DATA_W-1:0]   if_dat_o,
    output logic                              if_ack_o,
    output logic                              if_err_o,

    // Data port
    input  logic                              d_cyc_i,
    input  logic                              d_stb_i,
    input  logic                              d_we_i,
    input  logic [secv_mem_pkg::BUS_ADDR_W-1:0] d_adr_i,
    input  logic [secv_mem_pkg::SEL_W-1:0]    d_sel_i,
    input  logic [secv_mem_pkg::DATA_W-1:0]   d_dat_i,
    output logic [secv_mem_pkg::DATA_W-1:0]   d_dat_o,
    output logic                              d_ack_o,
    output logic                              d_err_o
);
    import secv_mem_pkg::*;

    // Master-side links from the ports
    wb_if #(.AW(BUS_ADDR_W)) m_if ();       // Fetch
    wb_if #(.AW(BUS_ADDR_W)) m_d ();        // Data

    // Shared bus after arbitration
    wb_if #(.AW(BUS_ADDR_W)) bus ();

    // Per-RAM links, region offset only
    wb_if #(.AW(IMEM_AW)) s_imem ();
    wb_if #(.AW(DMEM_AW)) s_dmem ();

    // Fetch port into its link
    assign m_if.cyc   = if_cyc_i;
    assign m_if.stb   = if_stb_i;
    assign m_if.we    = 1'b0;               // Never writes
    assign m_if.adr   = if_adr_i;
    assign m_if.sel   = if_sel_i;
    assign m_if.dat_w = '0;
    assign if_dat_o   = m_if.dat_r;
    assign if_ack_o   = m_if.ack;
    assign if_err_o   = m_if.err;

    // Data port into its link
    assign m_d.cyc   = d_cyc_i;
    assign m_d.stb   = d_stb_i;
    assign m_d.we    = d_we_i;
    assign m_d.adr   = d_adr_i;
    assign m_d.sel   = d_sel_i;
    assign m_d.dat_w = d_dat_i;
    assign d_dat_o   = m_d.dat_r;
    assign d_ack_o   = m_d.ack;
    assign d_err_o   = m_d.err;

    // Data wins on an idle bus, grant locked per cycle
    wb_arbiter u_arbiter (
        .clk_i     (clk_i),
        .RESET_MEM (RESET_MEM),
        .fetch_s   (m_if.slave),
        .data_s    (m_d.slave),
        .bus_m     (bus.master)
    );

    // Region select and unmapped err
    wb_decoder u_decoder (
        .clk_i     (clk_i),
        .RESET_MEM (RESET_MEM),
        .bus_s     (bus.slave),
        .imem_m    (s_imem.master),
        .dmem_m    (s_dmem.master)
    );

    // 1024 words at 0x000
    ram_wb #(.ADDR_WIDTH(IMEM_AW)) u_imem (
        .clk_i     (clk_i),
        .RESET_MEM (RESET_MEM),
        .bus_s     (s_imem.slave)
    );

    // 512 words at 0x800
    ram_wb #(.ADDR_WIDTH(DMEM_AW)) u_dmem (
        .clk_i     (clk_i),
        .RESET_MEM (RESET_MEM),
        .bus_s     (s_dmem.slave)
    );

endmodule

//--- tests/secv_mem_properties.sv
// Wishbone classic port checks on secv_mem_top, active only when assertions are enabled
`timescale 1ns/1ns

module secv_mem_properties (
    input logic clk_i,
    input logic RESET_MEM,
    input logic if_stb_i,
    input logic if_ack_i,       // Top-level if_ack_o
    input logic if_err_i,       // Top-level if_err_o
    input logic d_stb_i,
    input logic d_ack_i,        // Top-level d_ack_o
    input logic d_err_i         // Top-level d_err_o
);

    logic if_rsp;
    logic d_rsp;

    assign if_rsp = if_ack_i || if_err_i;   // Any termination
    assign d_rsp  = d_ack_i || d_err_i;

    // One kind of termination at a time
    a_if_one_term: assert property (@(posedge clk_i) !(if_ack_i && if_err_i))
        else $error("fetch port ack and err high together");
    a_d_one_term: assert property (@(posedge clk_i) !(d_ack_i && d_err_i))
        else $error("data port ack and err high together");

    // Response needs a strobe one cycle earlier
    a_if_after_stb: assert property (@(posedge clk_i) disable iff (RESET_MEM)
        if_rsp |-> $past(if_stb_i))
        else $error("fetch port response without a strobe");
    a_d_after_stb: assert property (@(posedge clk_i) disable iff (RESET_MEM)
        d_rsp |-> $past(d_stb_i))
        else $error("data port response without a strobe");

    // Registers are clear from the second reset cycle on
    a_if_reset_quiet: assert property (@(posedge clk_i)
        (RESET_MEM && $past(RESET_MEM)) |-> !if_rsp)
        else $error("fetch port response during reset");
    a_d_reset_quiet: assert property (@(posedge clk_i)
        (RESET_MEM && $past(RESET_MEM)) |-> !d_rsp)
        else $error("data port response during reset");

    // Single-cycle pulse
    a_if_pulse: assert property (@(posedge clk_i) disable iff (RESET_MEM)
        if_rsp |=> !(if_rsp && !if_stb_i))
        else $error("fetch port response held with strobe low");
    a_d_pulse: assert property (@(posedge clk_i) disable iff (RESET_MEM)
        d_rsp |=> !(d_rsp && !d_stb_i))
        else $error("data port response held with strobe low");

endmodule

bind secv_mem_top secv_mem_properties u_properties (
    .clk_i     (clk_i),
    .RESET_MEM (RESET_MEM),
    .if_stb_i  (if_stb_i),
    .if_ack_i  (if_ack_o),
    .if_err_i  (if_err_o),
    .d_stb_i   (d_stb_i),
    .d_ack_i   (d_ack_o),
    .d_err_i   (d_err_o)
);

//--- tests/secv_mem_tb.sv
// Needs assertions enabled and MEM_CLEAR_ON_RESET set, stops at the first failed check
`timescale 1ns/1ns

module secv_mem_tb;
    import secv_mem_pkg::*;

    localparam int MAX_WAIT = 16;       // Negedges before a port counts as stuck
    localparam logic [BUS_ADDR_W-1:0] IMEM_WORDS = BUS_ADDR_W'(2 ** IMEM_AW);
    localparam logic [BUS_ADDR_W-1:0] DMEM_WORDS = BUS_ADDR_W'(2 ** DMEM_AW);

    logic                  clk_i = 1'b0;
    logic                  RESET_MEM;
    logic                  if_cyc_i;
    logic                  if_stb_i;
    logic [BUS_ADDR_W-1:0] if_adr_i;
    logic [SEL_W-1:0]      if_sel_i;
    logic [DATA_W-1:0]     if_dat_o;
    logic                  if_ack_o;
    logic                  if_err_o;
    logic                  d_cyc_i;
    logic                  d_stb_i;
    logic                  d_we_i;
    logic [BUS_ADDR_W-1:0] d_adr_i;
    logic [SEL_W-1:0]      d_sel_i;
    logic [DATA_W-1:0]     d_dat_i;
    logic [DATA_W-1:0]     d_dat_o;
    logic                  d_ack_o;
    logic                  d_err_o;

    // Expected RAM contents by word
    logic [DATA_W-1:0]     imem_shadow [2**IMEM_AW];
    logic [DATA_W-1:0]     dmem_shadow [2**DMEM_AW];

    // Last response caught by a wait task
    logic [DATA_W-1:0]     rsp_dat;
    logic                  rsp_ack;
    logic                  rsp_err;
    int                    rsp_lat;        // Cycles from stb to response

    integer                seed = 32'hb07c_bdfc;
    logic [31:0]           rnd;
    logic [DATA_W-1:0]     wdata;
    logic [SEL_W-1:0]      sel;
    logic [BUS_ADDR_W-1:0] adr;
    logic [BUS_ADDR_W-1:0] written [$];    // Addresses hit by the random writes

    secv_mem_top secv_mem_top_inst (
        .clk_i     (clk_i),
        .RESET_MEM (RESET_MEM),
        .if_cyc_i  (if_cyc_i),
        .if_stb_i  (if_stb_i),
        .if_adr_i  (if_adr_i),
        .if_sel_i  (if_sel_i),
        .if_dat_o  (if_dat_o),
        .if_ack_o  (if_ack_o),
        .if_err_o  (if_err_o),
        .d_cyc_i   (d_cyc_i),
        .d_stb_i   (d_stb_i),
        .d_we_i    (d_we_i),
        .d_adr_i   (d_adr_i),
        .d_sel_i   (d_sel_i),
        .d_dat_i   (d_dat_i),
        .d_dat_o   (d_dat_o),
        .d_ack_o   (d_ack_o),
        .d_err_o   (d_err_o)
    );

    always #4 clk_i = ~clk_i;               // 8 ns period

    // Keep selected byte lanes and zero the rest
    function automatic logic [DATA_W-1:0] lanes_only(input logic [DATA_W-1:0] w,
                                                     input logic [SEL_W-1:0] s);
        logic [DATA_W-1:0] r;
        r = '0;
        for (int b = 0; b < SEL_W; b++) begin
            if (s[b]) begin
                r[8*b +: 8] = w[8*b +: 8];
            end
        end
        return r;
    endfunction

    // Region membership from base and size, wraps on purpose
    function automatic logic in_imem(input logic [BUS_ADDR_W-1:0] a);
        return (a - IMEM_BASE) < IMEM_WORDS;
    endfunction

    function automatic logic in_dmem(input logic [BUS_ADDR_W-1:0] a);
        return (a - DMEM_BASE) < DMEM_WORDS;
    endfunction

    function automatic logic [DATA_W-1:0] shadow_word(input logic [BUS_ADDR_W-1:0] a);
        logic [BUS_ADDR_W-1:0] off;
        off = in_imem(a) ? a - IMEM_BASE : a - DMEM_BASE;
        if (in_imem(a)) return imem_shadow[off[IMEM_AW-1:0]];
        if (in_dmem(a)) return dmem_shadow[off[DMEM_AW-1:0]];
        return '0;                          // Unmapped holds nothing
    endfunction

    // Byte merge of a write into the model
    task automatic shadow_write(input logic [BUS_ADDR_W-1:0] a, input logic [SEL_W-1:0] s,
                                input logic [DATA_W-1:0] w);
        logic [DATA_W-1:0] merged;
        merged = lanes_only(w, s) | lanes_only(shadow_word(a), ~s);
        if (in_imem(a)) imem_shadow[a - IMEM_BASE] = merged;
        else if (in_dmem(a)) dmem_shadow[(a - DMEM_BASE) & (DMEM_WORDS - 1'b1)] = merged;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    // Termination kind and optionally the one-cycle latency
    task automatic check_response(input string port, input logic exp_err, input logic one_cycle);
        check_value({port, "_ack_o"}, 32'(rsp_ack), 32'(!exp_err));
        check_value({port, "_err_o"}, 32'(rsp_err), 32'(exp_err));
        if (one_cycle) check_value({port, "_ack_o latency"}, rsp_lat, 32'h1);
    endtask

    // Request setup, caller picks the clock edge
    task automatic start_data(input logic we, input logic [BUS_ADDR_W-1:0] a,
                              input logic [SEL_W-1:0] s, input logic [DATA_W-1:0] w);
        d_cyc_i <= 1'b1;
        d_stb_i <= 1'b1;
        d_we_i  <= we;
        d_adr_i <= a;
        d_sel_i <= s;
        d_dat_i <= w;
    endtask

    task automatic start_fetch(input logic [BUS_ADDR_W-1:0] a, input logic [SEL_W-1:0] s);
        if_cyc_i <= 1'b1;
        if_stb_i <= 1'b1;
        if_adr_i <= a;
        if_sel_i <= s;
    endtask

    // Sample on negedges where outputs are settled
    task automatic wait_data(input logic fetch_quiet);
        int waited;
        waited = 0;
        do begin
            @(negedge clk_i);
            waited++;
            if (fetch_quiet) begin
                assert (!if_ack_o && !if_err_o)
                    else abort_run("Fetch port was answered while the data port owned the bus");
            end
            if (waited > MAX_WAIT) abort_run("Timeout waiting for ack or err on the data port");
        end while (!d_ack_o && !d_err_o);
        rsp_dat = d_dat_o;
        rsp_ack = d_ack_o;
        rsp_err = d_err_o;
        rsp_lat = waited - 1;               // First negedge is the stb cycle
    endtask

    task automatic wait_fetch();
        int waited;
        waited = 0;
        do begin
            @(negedge clk_i);
            waited++;
            if (waited > MAX_WAIT) abort_run("Timeout waiting for ack or err on the fetch port");
        end while (!if_ack_o && !if_err_o);
        rsp_dat = if_dat_o;
        rsp_ack = if_ack_o;
        rsp_err = if_err_o;
        rsp_lat = waited - 1;
    endtask

    // Single access with cyc dropped after the response
    task automatic data_access(input logic we, input logic [BUS_ADDR_W-1:0] a,
                               input logic [SEL_W-1:0] s, input logic [DATA_W-1:0] w);
        @(posedge clk_i);
        start_data(we, a, s, w);
        wait_data(1'b0);
        @(posedge clk_i);
        d_cyc_i <= 1'b0;
        d_stb_i <= 1'b0;
        if (we && rsp_ack) shadow_write(a, s, w);
    endtask

    task automatic fetch_access(input logic [BUS_ADDR_W-1:0] a, input logic [SEL_W-1:0] s);
        @(posedge clk_i);
        start_fetch(a, s);
        wait_fetch();
        @(posedge clk_i);
        if_cyc_i <= 1'b0;
        if_stb_i <= 1'b0;
    endtask

    initial begin
        imem_shadow = '{default: '0};       // Reset clears both RAMs
        dmem_shadow = '{default: '0};
        RESET_MEM = 1'b1;
        if_cyc_i = 1'b0;
        if_stb_i = 1'b0;
        if_adr_i = '0;
        if_sel_i = '0;
        d_cyc_i = 1'b0;
        d_stb_i = 1'b0;
        d_we_i = 1'b0;
        d_adr_i = '0;
        d_sel_i = '0;
        d_dat_i = '0;
        repeat (5) @(posedge clk_i);
        RESET_MEM <= 1'b0;

        // Fill the words read below, then reset once more
        rnd = $random(seed);
        data_access(1'b1, IMEM_BASE + {2'b00, rnd[9:0]}, 4'hf, '1);
        data_access(1'b1, DMEM_BASE + {3'b000, rnd[24:16]}, 4'hf, '1);
        data_access(1'b1, IMEM_BASE + {2'b00, rnd[25:16]}, 4'hf, '1);
        check_response("d", 1'b0, 1'b1);
        @(posedge clk_i);
        RESET_MEM <= 1'b1;
        repeat (5) @(posedge clk_i);
        RESET_MEM <= 1'b0;
        imem_shadow = '{default: '0};       // Cleared again by the second reset
        dmem_shadow = '{default: '0};

        // Cleared words read back as zero
        data_access(1'b0, IMEM_BASE + {2'b00, rnd[9:0]}, rnd[15:12], '0);
        check_response("d", 1'b0, 1'b1);
        check_value("d_dat_o", rsp_dat, 32'h0);
        data_access(1'b0, DMEM_BASE + {3'b000, rnd[24:16]}, rnd[31:28], '0);
        check_response("d", 1'b0, 1'b1);
        check_value("d_dat_o", rsp_dat, 32'h0);
        fetch_access(IMEM_BASE + {2'b00, rnd[25:16]}, 4'hf);
        check_response("if", 1'b0, 1'b1);
        check_value("if_dat_o", rsp_dat, 32'h0);

        // Random lane writes into a small window so merges overlap
        for (int i = 0; i < 24; i++) begin
            rnd = $random(seed);
            wdata = $random(seed);
            adr = (rnd[16] ? DMEM_BASE : IMEM_BASE) + {8'h00, rnd[3:0]};
            data_access(1'b1, adr, rnd[15:12], wdata);
            check_response("d", 1'b0, 1'b1);
            written.push_back(adr);
        end
        foreach (written[i]) begin
            rnd = $random(seed);
            sel = rnd[3:0];
            data_access(1'b0, written[i], sel, '0);
            check_response("d", 1'b0, 1'b1);
            check_value("d_dat_o", rsp_dat, lanes_only(shadow_word(written[i]), sel));
        end

        // Same offset in both regions keeps two different words
        rnd = $random(seed);
        wdata = $random(seed);
        data_access(1'b1, IMEM_BASE + {3'b000, rnd[8:0]}, 4'hf, wdata);
        data_access(1'b1, DMEM_BASE + {3'b000, rnd[8:0]}, 4'hf, ~wdata);
        data_access(1'b0, IMEM_BASE + {3'b000, rnd[8:0]}, 4'hf, '0);
        check_value("d_dat_o", rsp_dat, shadow_word(IMEM_BASE + {3'b000, rnd[8:0]}));
        data_access(1'b0, DMEM_BASE + {3'b000, rnd[8:0]}, 4'hf, '0);
        check_value("d_dat_o", rsp_dat, shadow_word(DMEM_BASE + {3'b000, rnd[8:0]}));
        fetch_access(IMEM_BASE + {3'b000, rnd[8:0]}, 4'hf);
        check_response("if", 1'b0, 1'b1);
        check_value("if_dat_o", rsp_dat, wdata);

        // Holes in the map answer with err and leave the RAMs alone
        rnd = $random(seed);
        data_access(1'b0, {2'b01, rnd[9:0]}, 4'hf, '0);
        check_response("d", 1'b1, 1'b1);
        data_access(1'b1, {2'b11, rnd[9:0]}, 4'hf, $random(seed));
        check_response("d", 1'b1, 1'b1);
        fetch_access({3'b101, rnd[8:0]}, 4'hf);
        check_response("if", 1'b1, 1'b1);
        data_access(1'b0, IMEM_BASE + {2'b00, rnd[9:0]}, 4'hf, '0);
        check_value("d_dat_o", rsp_dat, shadow_word(IMEM_BASE + {2'b00, rnd[9:0]}));
        data_access(1'b0, DMEM_BASE + {3'b000, rnd[8:0]}, 4'hf, '0);
        check_value("d_dat_o", rsp_dat, shadow_word(DMEM_BASE + {3'b000, rnd[8:0]}));

        // Both start on an idle bus, data goes first
        rnd = $random(seed);
        @(posedge clk_i);
        start_fetch(IMEM_BASE + {8'h00, rnd[3:0]}, 4'hf);
        start_data(1'b0, DMEM_BASE + {8'h00, rnd[7:4]}, 4'hf, '0);
        wait_data(1'b1);
        check_response("d", 1'b0, 1'b1);
        check_value("d_dat_o", rsp_dat, shadow_word(DMEM_BASE + {8'h00, rnd[7:4]}));
        @(posedge clk_i);
        d_cyc_i <= 1'b0;
        d_stb_i <= 1'b0;
        wait_fetch();                       // Served only after the release
        check_response("if", 1'b0, 1'b0);
        check_value("if_dat_o", rsp_dat, shadow_word(IMEM_BASE + {8'h00, rnd[3:0]}));
        @(posedge clk_i);
        if_cyc_i <= 1'b0;
        if_stb_i <= 1'b0;

        // Data keeps cyc over a write and a read of the word fetch wants
        adr = IMEM_BASE + {2'b00, rnd[25:16]};
        wdata = $random(seed);
        @(posedge clk_i);
        start_fetch(adr, 4'hf);
        start_data(1'b1, adr, 4'hf, wdata);
        wait_data(1'b1);
        check_response("d", 1'b0, 1'b1);
        shadow_write(adr, 4'hf, wdata);
        @(posedge clk_i);
        start_data(1'b0, adr, rnd[31:28], '0);  // Back to back under the same cyc
        wait_data(1'b1);
        check_response("d", 1'b0, 1'b1);
        check_value("d_dat_o", rsp_dat, lanes_only(shadow_word(adr), rnd[31:28]));
        @(posedge clk_i);
        d_cyc_i <= 1'b0;
        d_stb_i <= 1'b0;
        wait_fetch();
        check_response("if", 1'b0, 1'b0);
        check_value("if_dat_o", rsp_dat, shadow_word(adr));
        @(posedge clk_i);
        if_cyc_i <= 1'b0;
        if_stb_i <= 1'b0;
        repeat (2) @(posedge clk_i);        // Let the bound properties see the idle bus

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- secv_mem_top.f
common/secv_mem_pkg.sv
common/wb_if.sv
ram_wb/ram_wb.sv
hdl/wb_arbiter.sv
hdl/wb_decoder.sv
hdl/secv_mem_top.sv
tests/secv_mem_properties.sv
tests/secv_mem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compiles the memory subsystem testbench with Verilator and runs it
# Exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir
SIM=secv_mem_sim

rm -f "$LOG"

verilator --binary --timing --assert \
    --top-module secv_mem_tb \
    -f secv_mem_top.f \
    --Mdir "$BUILD" \
    -o "$SIM" > "$LOG" 2>&1 &&
    "./$BUILD/$SIM" >> "$LOG" 2>&1

grep -qx "Done: no errors" "$LOG" &&
    { echo "Simulation passed"; exit 0; } ||
    { echo "Simulation failed, see $LOG"; exit 1; }
